// File: design/decodeStage_cfg.svh
`ifndef DECODESTAGE_CFG_SVH
`define DECODESTAGE_CFG_SVH

`define XLEN       64
`define ILEN       32
`define REG_IDX_W  5

`define AXI_ADDR_W 8
`define AXI_DATA_W 32

// register map
`define DEC_CTRL_OFS     8'h00  // enable, haltOnIllegal, clearHalt
`define DEC_STATUS_OFS   8'h04  // halted, causeEbreak, causeIllegal
`define DEC_COUNT_OFS    8'h08
`define DEC_ILLCOUNT_OFS 8'h0C
`define DEC_LASTBAD_OFS  8'h10

`endif

// File: design/decodePkg.sv
`include "decodeStage_cfg.svh"

package decodePkg;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        LOAD    = 5'b00000,
        STORE   = 5'b01000,
        OPIMM   = 5'b00100,
        OPIMM32 = 5'b00110,
        OP      = 5'b01100,
        OP32    = 5'b01110,
        BRANCH  = 5'b11000,
        JAL     = 5'b11011,
        JALR    = 5'b11001,
        LUI     = 5'b01101,
        AUIPC   = 5'b00101,
        SYSTEM  = 5'b11100
    } opcodeE;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_J = 3'b001,
        IMM_S = 3'b010,
        IMM_B = 3'b011,
        IMM_U = 3'b101
    } immTypeE;

    typedef enum logic [2:0] {
        BR_NONE = 3'b000,
        BR_JAL  = 3'b001,
        BR_JALR = 3'b010,
        BR_EQ   = 3'b100,
        BR_NE   = 3'b101,
        BR_LT   = 3'b110,
        BR_GE   = 3'b111
    } branchE;

    typedef enum logic [1:0] {
        SRC_REG  = 2'd0,
        SRC_FOUR = 2'd1,
        SRC_IMM  = 2'd2
    } aluBSrcE;

    typedef struct packed {
        logic        regWr;
        logic        aluASrc;   // 1 selects pc
        aluBSrcE     aluBSrc;
        logic [5:0]  aluCtr;
        branchE      branch;
        logic        memRd;
        logic        memWr;
        logic        memToReg;
        logic [2:0]  memOp;
        logic        illegal;
        logic        ebreak;
    } ctrlT;

    typedef struct packed {
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      imm;
        ctrlT                  ctrl;
    } decodedT;

    typedef struct packed {
        logic [`AXI_ADDR_W-1:0]   awaddr;
        logic                     awvalid;
        logic [`AXI_DATA_W-1:0]   wdata;
        logic [`AXI_DATA_W/8-1:0] wstrb;
        logic                     wvalid;
        logic                     bready;
        logic [`AXI_ADDR_W-1:0]   araddr;
        logic                     arvalid;
        logic                     rready;
    } axiLiteReqT;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic [1:0]             bresp;
        logic                   bvalid;
        logic                   arready;
        logic [`AXI_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
        logic                   rvalid;
    } axiLiteRspT;

endpackage

// File: design/instrDecoder.sv
`include "decodeStage_cfg.svh"

module instrDecoder (
    input  logic [`ILEN-1:0]   instr,
    output decodePkg::ctrlT    ctrl,
    output decodePkg::immTypeE immType
);
    import decodePkg::*;

    opcodeE     opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       bad;

    assign opcode = opcodeE'(instr[6:2]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        ctrl = '0;
        immType = IMM_I;
        bad = 1'b0;
        ctrl.regWr = (opcode != BRANCH) && (opcode != STORE);
        ctrl.aluASrc = (opcode == AUIPC) || (opcode == JAL) || (opcode == JALR);
        ctrl.memRd = (opcode == LOAD);
        ctrl.memToReg = (opcode == LOAD);
        ctrl.memWr = (opcode == STORE);
        ctrl.memOp = funct3;
        ctrl.aluCtr[5] = (opcode == OP32) || (opcode == OP && funct7[0]);  // word or muldiv
        ctrl.aluCtr[4] = instr[3];
        case (opcode)
            LUI: begin
                immType = IMM_U;
                ctrl.aluBSrc = SRC_IMM;
                ctrl.aluCtr[3:0] = 4'b1111;  // pass b
            end
            AUIPC: begin
                immType = IMM_U;
                ctrl.aluBSrc = SRC_IMM;
            end
            JAL: begin
                immType = IMM_J;
                ctrl.aluBSrc = SRC_FOUR;
                ctrl.branch = BR_JAL;
            end
            JALR: begin
                ctrl.aluBSrc = SRC_FOUR;
                ctrl.branch = BR_JALR;
                bad = (funct3 != 3'b000);
            end
            BRANCH: begin
                immType = IMM_B;
                ctrl.aluCtr[3:0] = funct3[1] ? 4'b0011 : 4'b0010;  // unsigned compare
                case (funct3)
                    3'b000: ctrl.branch = BR_EQ;
                    3'b001: ctrl.branch = BR_NE;
                    3'b100, 3'b110: ctrl.branch = BR_LT;
                    3'b101, 3'b111: ctrl.branch = BR_GE;
                    default: bad = 1'b1;
                endcase
            end
            LOAD: begin
                ctrl.aluBSrc = SRC_IMM;
                bad = (funct3 == 3'b111);
            end
            STORE: begin
                immType = IMM_S;
                ctrl.aluBSrc = SRC_IMM;
                bad = funct3[2];
            end
            OPIMM: begin
                ctrl.aluBSrc = SRC_IMM;
                ctrl.aluCtr[3:0] = {funct7[5] && (funct3 == 3'b101), funct3};
                // funct7[0] is shamt[5] here
                bad = (funct3 == 3'b001 && funct7[6:1] != 6'b000000)
                    || (funct3 == 3'b101 && funct7[6:1] != 6'b000000
                        && funct7[6:1] != 6'b010000);
            end
            OPIMM32: begin
                ctrl.aluBSrc = SRC_IMM;
                ctrl.aluCtr[3:0] = {funct7[5] && (funct3 == 3'b101), funct3};
                bad = !(funct3 inside {3'b000, 3'b001, 3'b101})
                    || (funct3 == 3'b001 && funct7 != 7'h00)
                    || (funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20);
            end
            OP: begin
                ctrl.aluCtr[3:0] = {funct7[5], funct3};
                bad = !(funct7 inside {7'h00, 7'h20, 7'h01});
            end
            OP32: begin
                ctrl.aluCtr[3:0] = {funct7[5], funct3};
                case (funct7)
                    7'h00: bad = !(funct3 inside {3'b000, 3'b001, 3'b101});
                    7'h20: bad = !(funct3 inside {3'b000, 3'b101});
                    7'h01: bad = !(funct3 inside {3'b000, 3'b100, 3'b101, 3'b110, 3'b111});
                    default: bad = 1'b1;
                endcase
            end
            SYSTEM: begin
                ctrl.aluBSrc = SRC_FOUR;
                ctrl.branch = BR_JAL;
                ctrl.ebreak = 1'b1;
                bad = (instr != 32'h0010_0073);  // only ebreak supported
            end
            default: bad = 1'b1;
        endcase
        if (bad || instr[1:0] != 2'b11) begin
            ctrl = '0;
            ctrl.illegal = 1'b1;
        end
    end

endmodule

// File: design/immGen.sv
`include "decodeStage_cfg.svh"

module immGen (
    input  logic [`ILEN-1:0]   instr,
    input  decodePkg::immTypeE immType,
    output logic [`XLEN-1:0]   imm
);
    import decodePkg::*;

    always_comb begin
        case (immType)
            IMM_I: imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            IMM_S: imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B: begin
                imm = {{(`XLEN-13){instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            IMM_U: imm = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
            IMM_J: begin
                imm = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// File: design/decodePipe.sv
`include "decodeStage_cfg.svh"

module decodePipe (
    input  logic               clk,
    input  logic               reset,
    input  decodePkg::decodedT inData,
    input  logic [`ILEN-1:0]   inInstr,
    input  logic               inValid,
    output logic               inReady,
    input  logic               stall,
    output decodePkg::decodedT outData,
    output logic               outValid,
    input  logic               outReady,
    output logic               accept,
    output logic [`ILEN-1:0]   acceptInstr
);
    import decodePkg::*;

    assign inReady = !stall && (!outValid || outReady);
    assign accept = inValid && inReady;
    assign acceptInstr = inInstr;  // word of the entry being accepted

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (accept) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;  // drained
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outData <= inData;
        end
    end

endmodule

// File: design/decodeRegs.sv
`include "decodeStage_cfg.svh"

module decodeRegs (
    input  logic                  clk,
    input  logic                  reset,
    input  decodePkg::axiLiteReqT axiReq,
    output decodePkg::axiLiteRspT axiRsp,
    input  logic                  accept,
    input  decodePkg::ctrlT       acceptCtrl,
    input  logic [`ILEN-1:0]      acceptInstr,
    output logic                  stall
);
    import decodePkg::*;

    logic                   enable;
    logic                   haltOnIllegal;
    logic                   halted;
    logic                   causeEbreak;
    logic                   causeIllegal;
    logic [`AXI_DATA_W-1:0] decCount;
    logic [`AXI_DATA_W-1:0] illCount;
    logic [`ILEN-1:0]       lastBad;
    logic                   bValid;
    logic                   rValid;
    logic [`AXI_DATA_W-1:0] rdData;
    logic [`AXI_DATA_W-1:0] rdNext;
    logic                   wrAccept;
    logic                   rdAccept;

    assign wrAccept = axiReq.awvalid && axiReq.wvalid && !bValid;
    assign rdAccept = axiReq.arvalid && !rValid;
    assign stall = !enable || halted;

    always_comb begin
        axiRsp = '0;
        axiRsp.awready = wrAccept;
        axiRsp.wready = wrAccept;
        axiRsp.bvalid = bValid;  // bresp stays OKAY
        axiRsp.arready = !rValid;
        axiRsp.rdata = rdData;
        axiRsp.rvalid = rValid;
    end

    always_comb begin
        case (axiReq.araddr)
            `DEC_CTRL_OFS:     rdNext = {{(`AXI_DATA_W-2){1'b0}}, haltOnIllegal, enable};
            `DEC_STATUS_OFS:   rdNext = {{(`AXI_DATA_W-3){1'b0}}, causeIllegal, causeEbreak, halted};
            `DEC_COUNT_OFS:    rdNext = decCount;
            `DEC_ILLCOUNT_OFS: rdNext = illCount;
            `DEC_LASTBAD_OFS:  rdNext = lastBad;
            default:           rdNext = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bValid <= 1'b0;
            rValid <= 1'b0;
        end else begin
            if (wrAccept) begin
                bValid <= 1'b1;
            end else if (axiReq.bready) begin
                bValid <= 1'b0;
            end
            if (rdAccept) begin
                rValid <= 1'b1;
            end else if (axiReq.rready) begin
                rValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdAccept) begin
            rdData <= rdNext;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b0;
            haltOnIllegal <= 1'b0;
            halted <= 1'b0;
            causeEbreak <= 1'b0;
            causeIllegal <= 1'b0;
            decCount <= '0;
            illCount <= '0;
            lastBad <= '0;
        end else begin
            if (wrAccept && axiReq.awaddr == `DEC_CTRL_OFS) begin
                enable <= axiReq.wdata[0];
                haltOnIllegal <= axiReq.wdata[1];
                if (axiReq.wdata[2]) begin  // clearHalt
                    halted <= 1'b0;
                    causeEbreak <= 1'b0;
                    causeIllegal <= 1'b0;
                end
            end
            if (accept) begin
                decCount <= decCount + 1'b1;  // wraps
                if (acceptCtrl.illegal) begin
                    illCount <= illCount + 1'b1;
                    lastBad <= acceptInstr;
                end
                if (acceptCtrl.ebreak) begin
                    halted <= 1'b1;
                    causeEbreak <= 1'b1;
                end
                if (acceptCtrl.illegal && haltOnIllegal) begin
                    halted <= 1'b1;
                    causeIllegal <= 1'b1;
                end
            end
        end
    end

endmodule

// File: design/decodeStage.sv
`include "decodeStage_cfg.svh"

module decodeStage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`ILEN-1:0]      instr,
    input  logic                  inValid,
    output logic                  inReady,
    output decodePkg::decodedT    decoded,
    output logic                  outValid,
    input  logic                  outReady,
    input  decodePkg::axiLiteReqT axiReq,
    output decodePkg::axiLiteRspT axiRsp
);
    import decodePkg::*;

    ctrlT             ctrl;
    immTypeE          immType;
    logic [`XLEN-1:0] imm;
    decodedT          nextEntry;
    logic             stall;
    logic             accept;
    logic [`ILEN-1:0] acceptInstr;

    assign nextEntry = '{
        rs1:  instr[19:15],
        rs2:  instr[24:20],
        rd:   instr[11:7],
        imm:  imm,
        ctrl: ctrl
    };

    instrDecoder instrDecoder_inst (
        .instr   (instr),
        .ctrl    (ctrl),
        .immType (immType)
    );

    immGen immGen_inst (
        .instr   (instr),
        .immType (immType),
        .imm     (imm)
    );

    decodePipe decodePipe_inst (
        .clk         (clk),
        .reset       (reset),
        .inData      (nextEntry),
        .inInstr     (instr),
        .inValid     (inValid),
        .inReady     (inReady),
        .stall       (stall),
        .outData     (decoded),
        .outValid    (outValid),
        .outReady    (outReady),
        .accept      (accept),
        .acceptInstr (acceptInstr)
    );

    decodeRegs decodeRegs_inst (
        .clk         (clk),
        .reset       (reset),
        .axiReq      (axiReq),
        .axiRsp      (axiRsp),
        .accept      (accept),
        .acceptCtrl  (nextEntry.ctrl),
        .acceptInstr (acceptInstr),
        .stall       (stall)
    );

endmodule

// File: verification/decodeStageTb.sv
`include "decodeStage_cfg.svh"

module decodeStageTb;
    import decodePkg::*;

    localparam int clkPeriod = 4;
    localparam int testTotal = 6;
    localparam int cycleBudget = 500;  // per test

    logic             clk;
    logic             reset;
    logic [`ILEN-1:0] instr;
    logic             inValid;
    logic             inReady;
    decodedT          decoded;
    logic             outValid;
    logic             outReady;
    axiLiteReqT       axiReq;
    axiLiteRspT       axiRsp;

    decodedT expQ[$];  // entries expected at the output, in order
    decodedT expHead;
    integer  seed;
    int      errCount;
    int      testsRun;
    int      sentCount;
    int      illegalSent;

    decodeStage decodeStage_inst (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .inValid  (inValid),
        .inReady  (inReady),
        .decoded  (decoded),
        .outValid (outValid),
        .outReady (outReady),
        .axiReq   (axiReq),
        .axiRsp   (axiRsp)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // expected decode, built from the RV64IM encoding rules
    function automatic decodedT refDecode(input logic [`ILEN-1:0] w);
        decodedT                 d;
        logic [2:0]              f3;
        logic [6:0]              f7;
        logic                    legal;
        logic signed [`XLEN-1:0] s;
        d = '0;
        f3 = w[14:12];
        f7 = w[31:25];
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        d.rd = w[11:7];
        legal = (w[1:0] == 2'b11);
        s = $signed(w[31:20]);  // I format unless overridden
        d.ctrl.memOp = f3;
        d.ctrl.regWr = 1'b1;
        case (w[6:2])
            5'b01101: begin  // lui
                s = $signed({w[31:12], 12'h000});
                d.ctrl.aluBSrc = SRC_IMM;
                d.ctrl.aluCtr = 6'h0f;
            end
            5'b00101: begin  // auipc
                s = $signed({w[31:12], 12'h000});
                d.ctrl.aluASrc = 1'b1;
                d.ctrl.aluBSrc = SRC_IMM;
            end
            5'b11011: begin  // jal
                s = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
                d.ctrl.aluASrc = 1'b1;
                d.ctrl.aluBSrc = SRC_FOUR;
                d.ctrl.aluCtr = 6'h10;
                d.ctrl.branch = BR_JAL;
            end
            5'b11001: begin  // jalr
                d.ctrl.aluASrc = 1'b1;
                d.ctrl.aluBSrc = SRC_FOUR;
                d.ctrl.branch = BR_JALR;
                legal = legal && (f3 == 3'b000);
            end
            5'b11000: begin
                s = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
                d.ctrl.regWr = 1'b0;
                d.ctrl.aluCtr = f3[1] ? 6'h03 : 6'h02;
                case (f3)
                    3'b000: d.ctrl.branch = BR_EQ;
                    3'b001: d.ctrl.branch = BR_NE;
                    3'b100, 3'b110: d.ctrl.branch = BR_LT;
                    3'b101, 3'b111: d.ctrl.branch = BR_GE;
                    default: legal = 1'b0;
                endcase
            end
            5'b00000: begin
                d.ctrl.aluBSrc = SRC_IMM;
                d.ctrl.memRd = 1'b1;
                d.ctrl.memToReg = 1'b1;
                legal = legal && (f3 != 3'b111);
            end
            5'b01000: begin
                s = $signed({w[31:25], w[11:7]});
                d.ctrl.regWr = 1'b0;
                d.ctrl.aluBSrc = SRC_IMM;
                d.ctrl.memWr = 1'b1;
                legal = legal && (f3 < 3'd4);
            end
            5'b00100: begin
                d.ctrl.aluBSrc = SRC_IMM;
                d.ctrl.aluCtr = {2'b00, (f3 == 3'b101) && f7[5], f3};
                if (f3 == 3'b001)
                    legal = legal && (f7[6:1] == 6'b000000);
                if (f3 == 3'b101)
                    legal = legal && (f7[6:1] == 6'b000000 || f7[6:1] == 6'b010000);
            end
            5'b00110: begin
                d.ctrl.aluBSrc = SRC_IMM;
                d.ctrl.aluCtr = {2'b01, (f3 == 3'b101) && f7[5], f3};
                legal = legal && (f3 == 3'b000 || (f3 == 3'b001 && f7 == 7'h00)
                    || (f3 == 3'b101 && (f7 == 7'h00 || f7 == 7'h20)));
            end
            5'b01100: begin
                d.ctrl.aluCtr = {f7 == 7'h01, 1'b0, f7[5], f3};  // muldiv in bit 5
                legal = legal && (f7 == 7'h00 || f7 == 7'h20 || f7 == 7'h01);
            end
            5'b01110: begin
                d.ctrl.aluCtr = {2'b11, f7[5], f3};
                case (f7)
                    7'h00: legal = legal && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5);
                    7'h20: legal = legal && (f3 == 3'd0 || f3 == 3'd5);
                    7'h01: legal = legal && (f3 == 3'd0 || f3 >= 3'd4);
                    default: legal = 1'b0;
                endcase
            end
            5'b11100: begin
                d.ctrl.aluBSrc = SRC_FOUR;
                d.ctrl.branch = BR_JAL;
                d.ctrl.ebreak = 1'b1;
                legal = legal && (w == 32'h0010_0073);
            end
            default: legal = 1'b0;
        endcase
        d.imm = s;
        if (!legal) begin
            d.ctrl = '0;
            d.ctrl.illegal = 1'b1;
        end
        return d;
    endfunction

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {f7, 5'd3, 5'd2, f3, 5'd1, opc};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {imm, 5'd2, f3, 5'd1, opc};
    endfunction

    // one legal word per opcode, plus W and M forms
    function automatic logic [31:0] ctrlVector(input int i);
        case (i)
            0: return {20'hABCDE, 5'd1, 7'b0110111};
            1: return {20'h12345, 5'd2, 7'b0010111};
            2: return {20'h00102, 5'd1, 7'b1101111};
            3: return iType(12'h010, 3'd0, 7'b1100111);
            4: return rType(7'h00, 3'd0, 7'b1100011);
            5: return rType(7'h40, 3'd1, 7'b1100011);
            6: return rType(7'h00, 3'd6, 7'b1100011);
            7: return rType(7'h3f, 3'd5, 7'b1100011);
            8: return iType(12'h008, 3'd3, 7'b0000011);
            9: return iType(12'hf80, 3'd4, 7'b0000011);
            10: return rType(7'h01, 3'd3, 7'b0100011);
            11: return rType(7'h7f, 3'd0, 7'b0100011);
            12: return iType(12'hfff, 3'd0, 7'b0010011);
            13: return iType(12'h03f, 3'd1, 7'b0010011);
            14: return iType(12'h405, 3'd5, 7'b0010011);
            15: return iType(12'h123, 3'd3, 7'b0010011);
            16: return iType(12'h800, 3'd0, 7'b0011011);
            17: return iType(12'h41f, 3'd5, 7'b0011011);
            18: return rType(7'h00, 3'd0, 7'b0110011);
            19: return rType(7'h20, 3'd0, 7'b0110011);
            20: return rType(7'h01, 3'd0, 7'b0110011);
            21: return rType(7'h01, 3'd5, 7'b0110011);
            22: return rType(7'h20, 3'd0, 7'b0111011);
            23: return rType(7'h00, 3'd1, 7'b0111011);
            default: return rType(7'h01, 3'd7, 7'b0111011);
        endcase
    endfunction

    task automatic checkCtrl(input ctrlT got, input ctrlT exp, input string msg);
        if (got !== exp) begin
            errCount++;
            $display("ERR %0t: %s ctrl got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic checkDecoded(input decodedT got, input decodedT exp, input string msg);
        if (got.rs1 !== exp.rs1 || got.rs2 !== exp.rs2 || got.rd !== exp.rd) begin
            errCount++;
            $display("ERR %0t: %s rs1/rs2/rd got %0d/%0d/%0d, expected %0d/%0d/%0d", $time,
                     msg, got.rs1, got.rs2, got.rd, exp.rs1, exp.rs2, exp.rd);
        end
        if (got.imm !== exp.imm) begin
            errCount++;
            $display("ERR %0t: %s imm got %h, expected %h", $time, msg, got.imm, exp.imm);
        end
        checkCtrl(got.ctrl, exp.ctrl, msg);
    endtask

    task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            errCount++;
            $display("ERR %0t: %s got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            errCount++;
            $display("ERR %0t: %s got %b, expected %b", $time, msg, got, exp);
        end
    endtask

    // output side, sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && outValid && outReady) begin
            if (expQ.size() == 0) begin
                errCount++;
                $display("an output entry appeared at time %0t with none outstanding", $time);
            end else begin
                expHead = expQ.pop_front();
                checkDecoded(decoded, expHead, "output entry");
            end
        end
    end

    task automatic sendInstr(input logic [`ILEN-1:0] word);
        decodedT expEntry;
        expEntry = refDecode(word);
        expQ.push_back(expEntry);
        @(posedge clk);
        instr <= word;
        inValid <= 1'b1;
        @(negedge clk);
        while (!inReady) @(negedge clk);
        @(posedge clk);  // transfer edge
        inValid <= 1'b0;
        sentCount++;
        if (expEntry.ctrl.illegal)
            illegalSent++;
    endtask

    task automatic drainOutput();
        while (expQ.size() != 0) @(negedge clk);
    endtask

    task automatic axiWrite(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        axiReq.awaddr <= addr;
        axiReq.wdata <= data;
        axiReq.wstrb <= 4'hf;
        axiReq.awvalid <= 1'b1;
        axiReq.wvalid <= 1'b1;
        axiReq.bready <= 1'b1;
        @(negedge clk);
        while (!(axiRsp.awready && axiRsp.wready)) @(negedge clk);
        @(posedge clk);
        axiReq.awvalid <= 1'b0;
        axiReq.wvalid <= 1'b0;
        @(negedge clk);
        while (!axiRsp.bvalid) @(negedge clk);
        checkWord({30'b0, axiRsp.bresp}, 32'h0, "write response");
        @(posedge clk);
        axiReq.bready <= 1'b0;
    endtask

    task automatic axiRead(input logic [`AXI_ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        axiReq.araddr <= addr;
        axiReq.arvalid <= 1'b1;
        axiReq.rready <= 1'b1;
        @(negedge clk);
        while (!axiRsp.arready) @(negedge clk);
        @(posedge clk);
        axiReq.arvalid <= 1'b0;
        @(negedge clk);
        while (!axiRsp.rvalid) @(negedge clk);
        data = axiRsp.rdata;
        checkWord({30'b0, axiRsp.rresp}, 32'h0, "read response");
        @(posedge clk);
        axiReq.rready <= 1'b0;
    endtask

    task automatic readExpect(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] exp,
                              input string msg);
        logic [31:0] data;
        axiRead(addr, data);
        checkWord(data, exp, msg);
    endtask

    task automatic finishTest(input string name, input int errBefore);
        testsRun++;
        if (errCount == errBefore)
            $display("test %s: passed", name);
        else
            $display("test %s: failed with %0d errors", name, errCount - errBefore);
    endtask

    task automatic testResetState();
        int errBefore;
        errBefore = errCount;
        @(negedge clk);
        checkBit(inReady, 1'b0, "inReady after reset");
        checkBit(outValid, 1'b0, "outValid after reset");
        readExpect(`DEC_CTRL_OFS, 32'h0, "CTRL after reset");
        readExpect(`DEC_STATUS_OFS, 32'h0, "STATUS after reset");
        readExpect(`DEC_COUNT_OFS, 32'h0, "COUNT after reset");
        readExpect(`DEC_ILLCOUNT_OFS, 32'h0, "ILLCOUNT after reset");
        readExpect(`DEC_LASTBAD_OFS, 32'h0, "LASTBAD after reset");
        axiWrite(`DEC_CTRL_OFS, 32'h1);
        @(negedge clk);
        checkBit(inReady, 1'b1, "inReady after enable");
        finishTest("reset state", errBefore);
    endtask

    task automatic testImmediates();
        int          errBefore;
        int          k;
        int          n;
        logic [31:0] r;
        logic [31:0] word;
        errBefore = errCount;
        for (k = 0; k < 5; k++) begin
            for (n = 0; n < 8; n++) begin
                r = $random(seed);
                case (k)
                    0: word = {r[31:15], 3'b000, r[11:7], 7'b0010011};  // addi
                    1: word = {r[31:15], 3'b011, r[11:7], 7'b0100011};  // sd
                    2: word = {r[31:15], 3'b000, r[11:7], 7'b1100011};  // beq
                    3: word = {r[31:7], 7'b0110111};  // lui
                    default: word = {r[31:7], 7'b1101111};  // jal
                endcase
                sendInstr(word);
            end
        end
        drainOutput();
        finishTest("immediates", errBefore);
    endtask

    task automatic testControl();
        int          errBefore;
        int          i;
        logic [31:0] word;
        errBefore = errCount;
        for (i = 0; i < 25; i++) begin
            word = ctrlVector(i);
            sendInstr(word);
            @(negedge clk);
            checkBit(decoded.ctrl.illegal, 1'b0, "illegal flag of control vector");
        end
        drainOutput();
        finishTest("control fields", errBefore);
    endtask

    task automatic testBackPressure();
        int          errBefore;
        logic [31:0] first;
        decodedT     firstExp;
        errBefore = errCount;
        first = iType(12'h7a5, 3'd0, 7'b0010011);
        firstExp = refDecode(first);
        @(posedge clk);
        outReady <= 1'b0;
        sendInstr(first);
        fork
            sendInstr(rType(7'h20, 3'd5, 7'b0110011));
            begin
                repeat (5) begin
                    @(negedge clk);
                    checkDecoded(decoded, firstExp, "held entry");
                    checkBit(outValid, 1'b1, "outValid while held");
                    checkBit(inReady, 1'b0, "inReady while held");
                end
                @(posedge clk);
                outReady <= 1'b1;
            end
        join
        drainOutput();
        finishTest("back-pressure", errBefore);
    endtask

    task automatic testIllegal();
        int          errBefore;
        logic [31:0] bad;
        errBefore = errCount;
        axiWrite(`DEC_CTRL_OFS, 32'h1);
        sendInstr(32'hffff_ffff);  // unknown opcode
        drainOutput();
        @(negedge clk);
        checkBit(inReady, 1'b1, "inReady after illegal without halt");
        readExpect(`DEC_STATUS_OFS, 32'h0, "STATUS without halt");
        readExpect(`DEC_ILLCOUNT_OFS, illegalSent, "ILLCOUNT");
        readExpect(`DEC_LASTBAD_OFS, 32'hffff_ffff, "LASTBAD");
        axiWrite(`DEC_CTRL_OFS, 32'h3);
        bad = rType(7'h02, 3'd0, 7'b0110011);
        sendInstr(bad);
        drainOutput();
        repeat (3) begin
            @(negedge clk);
            checkBit(inReady, 1'b0, "inReady while halted");
        end
        readExpect(`DEC_STATUS_OFS, 32'h5, "STATUS after illegal halt");
        readExpect(`DEC_LASTBAD_OFS, bad, "LASTBAD after halt");
        readExpect(`DEC_ILLCOUNT_OFS, illegalSent, "ILLCOUNT after halt");
        axiWrite(`DEC_CTRL_OFS, 32'h5);  // clear halt, keep enable
        readExpect(`DEC_STATUS_OFS, 32'h0, "STATUS after clear");
        @(negedge clk);
        checkBit(inReady, 1'b1, "inReady after clear");
        sendInstr(iType(12'h001, 3'd0, 7'b0010011));
        drainOutput();
        finishTest("illegal handling", errBefore);
    endtask

    task automatic testEbreak();
        int errBefore;
        errBefore = errCount;
        sendInstr(32'h0010_0073);
        drainOutput();
        @(negedge clk);
        checkBit(inReady, 1'b0, "inReady after ebreak");
        readExpect(`DEC_STATUS_OFS, 32'h3, "STATUS after ebreak");
        readExpect(`DEC_COUNT_OFS, sentCount, "decoded count");
        axiWrite(`DEC_CTRL_OFS, 32'h5);
        readExpect(`DEC_STATUS_OFS, 32'h0, "STATUS after clear");
        readExpect(`DEC_CTRL_OFS, 32'h1, "CTRL after clear");
        finishTest("ebreak", errBefore);
    endtask

    initial begin
        #(testTotal * cycleBudget * clkPeriod);
        $display("timeout: tests did not complete within %0d cycles", testTotal * cycleBudget);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instr = '0;
        inValid = 1'b0;
        outReady = 1'b1;
        axiReq = '0;
        seed = 32'h722d_3e49;
        errCount = 0;
        testsRun = 0;
        sentCount = 0;
        illegalSent = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        testResetState();
        testImmediates();
        testControl();
        testBackPressure();
        testIllegal();
        testEbreak();
        $display("tests run %0d, errors %0d", testsRun, errCount);
        if (errCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: decodeStage.f
+incdir+design
design/decodePkg.sv
design/instrDecoder.sv
design/immGen.sv
design/decodePipe.sv
design/decodeRegs.sv
design/decodeStage.sv
verification/decodeStageTb.sv

// File: Bender.yml
package:
  name: decodeStage

sources:
  - include_dirs:
      - design
    files:
      - design/decodePkg.sv
      - design/instrDecoder.sv
      - design/immGen.sv
      - design/decodePipe.sv
      - design/decodeRegs.sv
      - design/decodeStage.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/decodeStageTb.sv
